//--- verilog/rename_pkg.sv
`default_nettype none

package rename_pkg;

  // Register counts
  localparam int ARCH_REGS = 32;
  localparam int PHYS_REGS = 64;
  localparam int LANES = 2;

  typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
  typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

  // One bit per physical register
  typedef logic [PHYS_REGS-1:0] phys_mask_t;

  // One lane of a rename request
  typedef struct packed {
    logic      valid;
    arch_idx_t rs1;
    arch_idx_t rs2;
    arch_idx_t rd;
  } rename_req_t;

  // One lane of a rename response
  typedef struct packed {
    logic      valid;
    phys_tag_t rs1_tag;
    phys_tag_t rs2_tag;
    phys_tag_t rd_tag;
    logic      has_rd;
  } rename_rsp_t;

  // One retiring instruction
  typedef struct packed {
    logic      valid;
    arch_idx_t rd;
    phys_tag_t tag;
  } commit_t;

endpackage

`default_nettype wire

//--- verilog/arch_map.sv
`timescale 1ns/1ps
`default_nettype none

module arch_map (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire rename_pkg::arch_idx_t          rd_idx [2*rename_pkg::LANES],
  output rename_pkg::phys_tag_t               rd_tag [2*rename_pkg::LANES],
  input  wire logic [rename_pkg::LANES-1:0]   wr_en,
  input  wire rename_pkg::arch_idx_t          wr_idx [rename_pkg::LANES],
  input  wire rename_pkg::phys_tag_t          wr_tag [rename_pkg::LANES],
  input  wire logic                           restore,
  input  wire rename_pkg::phys_tag_t          restore_map [rename_pkg::ARCH_REGS],
  output rename_pkg::phys_tag_t               dump [rename_pkg::ARCH_REGS]
);

  rename_pkg::phys_tag_t map_q [rename_pkg::ARCH_REGS];

  // Combinational read ports
  always_comb begin
    for (int i = 0; i < 2*rename_pkg::LANES; i++) begin
      rd_tag[i] = map_q[rd_idx[i]];
    end
  end

  assign dump = map_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity mapping out of reset
      for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
        map_q[i] <= rename_pkg::phys_tag_t'(i);
      end
    end else if (restore) begin
      map_q <= restore_map;
    end else begin
      // Higher lane is younger and wins on equal index
      for (int l = 0; l < rename_pkg::LANES; l++) begin
        if (wr_en[l]) begin
          map_q[wr_idx[l]] <= wr_tag[l];
        end
      end
    end
  end

  // Flush comes only while no rename is in flight
  a_restore_no_write: assert property (
    @(posedge clk) disable iff (rst)
    restore |-> (wr_en == '0)
  );

endmodule

`default_nettype wire

//--- verilog/free_pool.sv
`timescale 1ns/1ps
`default_nettype none

module free_pool (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic [rename_pkg::LANES-1:0] alloc_en,
  output rename_pkg::phys_tag_t             alloc_tag [rename_pkg::LANES],
  output logic [6:0]                        free_count,
  input  wire rename_pkg::commit_t          commit_set [rename_pkg::LANES],
  input  wire rename_pkg::phys_tag_t        release_tag [rename_pkg::LANES],
  input  wire logic                         flush
);

  // Tags below ARCH_REGS back the reset mapping
  localparam rename_pkg::phys_mask_t RESET_BUSY = {
    {(rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS){1'b0}},
    {rename_pkg::ARCH_REGS{1'b1}}
  };

  rename_pkg::phys_mask_t spec_busy;
  rename_pkg::phys_mask_t commit_busy;
  rename_pkg::phys_mask_t commit_busy_next;
  rename_pkg::phys_mask_t free_mask;
  rename_pkg::phys_mask_t alloc_mask;
  rename_pkg::phys_mask_t set_mask;
  rename_pkg::phys_mask_t clr_mask;
  rename_pkg::phys_tag_t  lowest;
  rename_pkg::phys_tag_t  second;

  function automatic rename_pkg::phys_tag_t lowest_set(input rename_pkg::phys_mask_t mask);
    rename_pkg::phys_tag_t tag;
    tag = '0;
    for (int i = rename_pkg::PHYS_REGS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        tag = rename_pkg::phys_tag_t'(i);
      end
    end
    return tag;
  endfunction

  always_comb begin
    free_mask = ~spec_busy;
    lowest = lowest_set(free_mask);
    second = lowest_set(free_mask & ~(rename_pkg::phys_mask_t'(1) << lowest));
    free_count = 7'($countones(free_mask));
    // A lone lane 1 takes the lowest tag
    alloc_tag[0] = lowest;
    alloc_tag[1] = alloc_en[0] ? second : lowest;
  end

  always_comb begin
    alloc_mask = '0;
    set_mask = '0;
    clr_mask = '0;
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      if (alloc_en[l]) begin
        alloc_mask[alloc_tag[l]] = 1'b1;
      end
      if (commit_set[l].valid) begin
        set_mask[commit_set[l].tag] = 1'b1;
        clr_mask[release_tag[l]] = 1'b1;
      end
    end
    // Release wins so lane 1 may free lane 0's new tag
    commit_busy_next = (commit_busy | set_mask) & ~clr_mask;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      spec_busy <= RESET_BUSY;
      commit_busy <= RESET_BUSY;
    end else begin
      commit_busy <= commit_busy_next;
      if (flush) begin
        spec_busy <= commit_busy_next;
      end else begin
        spec_busy <= (spec_busy | alloc_mask) & ~clr_mask;
      end
    end
  end

  for (genvar l = 0; l < rename_pkg::LANES; l++) begin : g_alloc_chk
    a_alloc_free: assert property (
      @(posedge clk) disable iff (rst)
      alloc_en[l] |-> !spec_busy[alloc_tag[l]]
    );
  end

endmodule

`default_nettype wire

//--- verilog/rename_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         req,
  input  wire rename_pkg::rename_req_t      req_group [rename_pkg::LANES],
  output logic                              ack,
  output rename_pkg::rename_rsp_t           rsp_group [rename_pkg::LANES],
  output rename_pkg::arch_idx_t             src_idx [2*rename_pkg::LANES],
  input  wire rename_pkg::phys_tag_t        src_tag [2*rename_pkg::LANES],
  output logic [rename_pkg::LANES-1:0]      map_wr_en,
  output rename_pkg::arch_idx_t             map_wr_idx [rename_pkg::LANES],
  output logic [rename_pkg::LANES-1:0]      alloc_en,
  input  wire rename_pkg::phys_tag_t        alloc_tag [rename_pkg::LANES],
  input  wire logic [6:0]                   free_count
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACKED,
    ST_DROP
  } state_t;

  state_t                       state;
  logic [rename_pkg::LANES-1:0] need_rd;
  logic [1:0]                   need_count;
  logic                         grant;
  rename_pkg::rename_rsp_t      rsp_next [rename_pkg::LANES];

  // x0 reads tag 0 and an older lane's new rd overrides the map
  function automatic rename_pkg::phys_tag_t src_lookup(
    input rename_pkg::arch_idx_t src,
    input rename_pkg::phys_tag_t mapped,
    input logic                  fwd_en,
    input rename_pkg::arch_idx_t fwd_rd,
    input rename_pkg::phys_tag_t fwd_tag
  );
    rename_pkg::phys_tag_t tag;
    if (src == '0) begin
      tag = '0;
    end else if (fwd_en && src == fwd_rd) begin
      tag = fwd_tag;
    end else begin
      tag = mapped;
    end
    return tag;
  endfunction

  always_comb begin
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      src_idx[2*l] = req_group[l].rs1;
      src_idx[2*l+1] = req_group[l].rs2;
      map_wr_idx[l] = req_group[l].rd;
      need_rd[l] = req_group[l].valid && (req_group[l].rd != '0);
    end
    need_count = 2'($countones(need_rd));
    // Stall until the pool covers every destination
    grant = (state == ST_IDLE) && req && (free_count >= 7'(need_count));
    alloc_en = need_rd & {rename_pkg::LANES{grant}};
    map_wr_en = alloc_en;
  end

  always_comb begin
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      rsp_next[l].valid = req_group[l].valid;
      rsp_next[l].rs1_tag = src_lookup(req_group[l].rs1, src_tag[2*l],
                                       (l != 0) && need_rd[0], req_group[0].rd, alloc_tag[0]);
      rsp_next[l].rs2_tag = src_lookup(req_group[l].rs2, src_tag[2*l+1],
                                       (l != 0) && need_rd[0], req_group[0].rd, alloc_tag[0]);
      rsp_next[l].rd_tag = need_rd[l] ? alloc_tag[l] : '0;
      rsp_next[l].has_rd = need_rd[l];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      for (int l = 0; l < rename_pkg::LANES; l++) begin
        rsp_group[l].valid <= 1'b0;
      end
    end else begin
      case (state)
        ST_IDLE: begin
          if (grant) begin
            rsp_group <= rsp_next;
            state <= ST_ACKED;
          end
        end
        ST_ACKED: begin
          if (!req) begin
            state <= ST_DROP;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign ack = (state != ST_IDLE);

  // Requester holds req until ack
  a_req_held: assert property (
    @(posedge clk) disable iff (rst)
    (req && !ack) |=> req
  );

endmodule

`default_nettype wire

//--- verilog/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    req,
  input  wire rename_pkg::rename_req_t req_group [rename_pkg::LANES],
  output logic                         ack,
  output rename_pkg::rename_rsp_t      rsp_group [rename_pkg::LANES],
  input  wire rename_pkg::commit_t     commit_group [rename_pkg::LANES],
  input  wire logic                    flush
);

  rename_pkg::arch_idx_t        src_idx [2*rename_pkg::LANES];
  rename_pkg::phys_tag_t        src_tag [2*rename_pkg::LANES];
  logic [rename_pkg::LANES-1:0] map_wr_en;
  rename_pkg::arch_idx_t        map_wr_idx [rename_pkg::LANES];
  logic [rename_pkg::LANES-1:0] alloc_en;
  rename_pkg::phys_tag_t        alloc_tag [rename_pkg::LANES];
  logic [6:0]                   free_count;
  rename_pkg::phys_tag_t        commit_dump [rename_pkg::ARCH_REGS];
  rename_pkg::arch_idx_t        commit_idx [2*rename_pkg::LANES];
  rename_pkg::phys_tag_t        old_tag [2*rename_pkg::LANES];
  logic [rename_pkg::LANES-1:0] commit_we;
  rename_pkg::arch_idx_t        commit_rd [rename_pkg::LANES];
  rename_pkg::phys_tag_t        commit_tag [rename_pkg::LANES];
  rename_pkg::commit_t          commit_set [rename_pkg::LANES];
  rename_pkg::phys_tag_t        release_tag [rename_pkg::LANES];

  always_comb begin
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      commit_set[l] = commit_group[l];
      commit_set[l].valid = commit_group[l].valid && (commit_group[l].rd != '0);
      commit_we[l] = commit_set[l].valid;
      commit_rd[l] = commit_group[l].rd;
      commit_tag[l] = commit_group[l].tag;
      commit_idx[l] = commit_group[l].rd;
      commit_idx[l + rename_pkg::LANES] = '0;
    end
    release_tag[0] = old_tag[0];
    // Lane 0's tag dies at once when both lanes commit the same rd
    if (commit_set[0].valid && commit_set[1].valid && commit_rd[0] == commit_rd[1]) begin
      release_tag[1] = commit_tag[0];
    end else begin
      release_tag[1] = old_tag[1];
    end
  end

  rename_ctrl i_rename_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_group  (req_group),
    .ack        (ack),
    .rsp_group  (rsp_group),
    .src_idx    (src_idx),
    .src_tag    (src_tag),
    .map_wr_en  (map_wr_en),
    .map_wr_idx (map_wr_idx),
    .alloc_en   (alloc_en),
    .alloc_tag  (alloc_tag),
    .free_count (free_count)
  );

  free_pool i_free_pool (
    .clk         (clk),
    .rst         (rst),
    .alloc_en    (alloc_en),
    .alloc_tag   (alloc_tag),
    .free_count  (free_count),
    .commit_set  (commit_set),
    .release_tag (release_tag),
    .flush       (flush)
  );

  arch_map spec_map (
    .clk         (clk),
    .rst         (rst),
    .rd_idx      (src_idx),
    .rd_tag      (src_tag),
    .wr_en       (map_wr_en),
    .wr_idx      (map_wr_idx),
    .wr_tag      (alloc_tag),
    .restore     (flush),
    .restore_map (commit_dump),
    .dump        ()
  );

  arch_map commit_map (
    .clk         (clk),
    .rst         (rst),
    .rd_idx      (commit_idx),
    .rd_tag      (old_tag),
    .wr_en       (commit_we),
    .wr_idx      (commit_rd),
    .wr_tag      (commit_tag),
    .restore     (1'b0),
    .restore_map (commit_dump),
    .dump        (commit_dump)
  );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

  localparam int TESTS = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic                    clk;
  logic                    rst;
  logic                    req;
  logic                    ack;
  logic                    flush;
  rename_pkg::rename_req_t req_group [rename_pkg::LANES];
  rename_pkg::rename_rsp_t rsp_group [rename_pkg::LANES];
  rename_pkg::commit_t     commit_group [rename_pkg::LANES];

  int errors;

  // Reference model of both maps and both busy sets
  rename_pkg::phys_tag_t  m_spec [rename_pkg::ARCH_REGS];
  rename_pkg::phys_tag_t  m_commit [rename_pkg::ARCH_REGS];
  rename_pkg::phys_mask_t m_spec_busy;
  rename_pkg::phys_mask_t m_commit_busy;

  clock_gen i_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  rename_unit i_rename_unit (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .req_group    (req_group),
    .ack          (ack),
    .rsp_group    (rsp_group),
    .commit_group (commit_group),
    .flush        (flush)
  );

  function automatic rename_pkg::arch_idx_t random_reg();
    return rename_pkg::arch_idx_t'($urandom_range(rename_pkg::ARCH_REGS - 1, 1));
  endfunction

  function automatic rename_pkg::rename_req_t make_req(
    input logic                  valid,
    input rename_pkg::arch_idx_t rs1,
    input rename_pkg::arch_idx_t rs2,
    input rename_pkg::arch_idx_t rd
  );
    rename_pkg::rename_req_t r;
    r.valid = valid;
    r.rs1 = rs1;
    r.rs2 = rs2;
    r.rd = rd;
    return r;
  endfunction

  function automatic rename_pkg::commit_t make_commit(
    input rename_pkg::arch_idx_t rd,
    input rename_pkg::phys_tag_t tag
  );
    rename_pkg::commit_t c;
    c.valid = (rd != '0);
    c.rd = rd;
    c.tag = tag;
    return c;
  endfunction

  task automatic init_model();
    for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
      m_spec[i] = rename_pkg::phys_tag_t'(i);
      m_commit[i] = rename_pkg::phys_tag_t'(i);
    end
    m_spec_busy = '0;
    for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
      m_spec_busy[i] = 1'b1;
    end
    m_commit_busy = m_spec_busy;
  endtask

  function automatic rename_pkg::phys_tag_t first_free();
    rename_pkg::phys_tag_t t;
    logic                  found;
    t = '0;
    found = 1'b0;
    for (int i = 0; i < rename_pkg::PHYS_REGS; i++) begin
      if (!found && !m_spec_busy[i]) begin
        t = rename_pkg::phys_tag_t'(i);
        found = 1'b1;
      end
    end
    return t;
  endfunction

  function automatic int count_free();
    int n;
    n = 0;
    for (int i = 0; i < rename_pkg::PHYS_REGS; i++) begin
      if (!m_spec_busy[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // Map lookup with x0 and the older lane's new destination applied
  function automatic rename_pkg::phys_tag_t expected_source(
    input rename_pkg::arch_idx_t src,
    input logic                  fwd,
    input rename_pkg::arch_idx_t fwd_rd,
    input rename_pkg::phys_tag_t fwd_tag
  );
    if (src == '0) begin
      return '0;
    end
    if (fwd && src == fwd_rd) begin
      return fwd_tag;
    end
    return m_spec[src];
  endfunction

  task automatic predict_rename(
    input  rename_pkg::rename_req_t g0,
    input  rename_pkg::rename_req_t g1,
    output rename_pkg::rename_rsp_t e0,
    output rename_pkg::rename_rsp_t e1
  );
    logic                  need0;
    logic                  need1;
    rename_pkg::phys_tag_t tag0;
    rename_pkg::phys_tag_t tag1;
    need0 = g0.valid && (g0.rd != '0);
    need1 = g1.valid && (g1.rd != '0);
    tag0 = '0;
    tag1 = '0;
    if (need0) begin
      tag0 = first_free();
      m_spec_busy[tag0] = 1'b1;
    end
    if (need1) begin
      tag1 = first_free();
      m_spec_busy[tag1] = 1'b1;
    end
    e0.valid = g0.valid;
    e0.rs1_tag = expected_source(g0.rs1, 1'b0, g0.rd, tag0);
    e0.rs2_tag = expected_source(g0.rs2, 1'b0, g0.rd, tag0);
    e0.rd_tag = tag0;
    e0.has_rd = need0;
    e1.valid = g1.valid;
    e1.rs1_tag = expected_source(g1.rs1, need0, g0.rd, tag0);
    e1.rs2_tag = expected_source(g1.rs2, need0, g0.rd, tag0);
    e1.rd_tag = tag1;
    e1.has_rd = need1;
    // Younger lane lands last
    if (need0) begin
      m_spec[g0.rd] = tag0;
    end
    if (need1) begin
      m_spec[g1.rd] = tag1;
    end
  endtask

  task automatic apply_commit(input rename_pkg::commit_t c);
    rename_pkg::phys_tag_t old;
    if (c.valid && c.rd != '0) begin
      old = m_commit[c.rd];
      m_commit[c.rd] = c.tag;
      m_commit_busy[c.tag] = 1'b1;
      m_commit_busy[old] = 1'b0;
      m_spec_busy[old] = 1'b0;
    end
  endtask

  // Tags of an invalid lane carry no meaning
  function automatic rename_pkg::rename_rsp_t hide_tags(input rename_pkg::rename_rsp_t r);
    rename_pkg::rename_rsp_t h;
    h = r;
    if (!r.valid) begin
      h.rs1_tag = '0;
      h.rs2_tag = '0;
      h.rd_tag = '0;
    end
    return h;
  endfunction

  task automatic check_rsp(
    input string                   name,
    input int                      lane,
    input rename_pkg::rename_rsp_t expected,
    input rename_pkg::rename_rsp_t actual
  );
    if (actual !== expected) begin
      $display("Error %s lane %0d: expected %h actual %h", name, lane, expected, actual);
      errors++;
    end
  endtask

  task automatic check_ack(
    input  string name,
    input  logic  expect_ack,
    input  int    max_cycles,
    output logic  got
  );
    got = 1'b0;
    for (int i = 0; i < max_cycles && !got; i++) begin
      @(negedge clk);
      got = ack;
    end
    if (got !== expect_ack) begin
      $display("Error %s: ack expected %0b actual %0b", name, expect_ack, got);
      errors++;
    end
  endtask

  task automatic send_req(input rename_pkg::rename_req_t g0, input rename_pkg::rename_req_t g1);
    @(posedge clk);
    req_group[0] <= g0;
    req_group[1] <= g1;
    req <= 1'b1;
  endtask

  task automatic release_req(input string name);
    logic low;
    @(posedge clk);
    req <= 1'b0;
    low = 1'b0;
    for (int i = 0; i < 10 && !low; i++) begin
      @(negedge clk);
      low = !ack;
    end
    if (!low) begin
      $display("%s: ack stayed high after req was dropped", name);
      errors++;
    end
  endtask

  task automatic await_rsp(
    input string                   name,
    input rename_pkg::rename_rsp_t e0,
    input rename_pkg::rename_rsp_t e1
  );
    logic got;
    check_ack(name, 1'b1, 40, got);
    if (got) begin
      check_rsp(name, 0, hide_tags(e0), hide_tags(rsp_group[0]));
      check_rsp(name, 1, hide_tags(e1), hide_tags(rsp_group[1]));
    end
    release_req(name);
  endtask

  task automatic rename_group(
    input string                   name,
    input rename_pkg::rename_req_t g0,
    input rename_pkg::rename_req_t g1
  );
    rename_pkg::rename_rsp_t e0;
    rename_pkg::rename_rsp_t e1;
    predict_rename(g0, g1, e0, e1);
    send_req(g0, g1);
    await_rsp(name, e0, e1);
  endtask

  task automatic pulse_commit(input rename_pkg::commit_t c0, input rename_pkg::commit_t c1);
    @(posedge clk);
    commit_group[0] <= c0;
    commit_group[1] <= c1;
    @(posedge clk);
    commit_group[0] <= '0;
    commit_group[1] <= '0;
    apply_commit(c0);
    apply_commit(c1);
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    m_spec = m_commit;
    m_spec_busy = m_commit_busy;
  endtask

  task automatic reset_mapping();
    rename_group("reset_map",
                 make_req(1'b1, random_reg(), random_reg(), random_reg()),
                 make_req(1'b1, random_reg(), random_reg(), random_reg()));
  endtask

  task automatic lane_forwarding();
    rename_pkg::arch_idx_t r;
    r = random_reg();
    rename_group("fwd_group", make_req(1'b1, random_reg(), random_reg(), r),
                 make_req(1'b1, r, r, r));
    rename_group("fwd_next", make_req(1'b1, r, r, '0), make_req(1'b1, r, '0, '0));
  endtask

  task automatic zero_register();
    rename_group("x0_dest", make_req(1'b1, '0, random_reg(), '0),
                 make_req(1'b0, random_reg(), random_reg(), random_reg()));
    rename_group("x0_after", make_req(1'b1, '0, '0, random_reg()),
                 make_req(1'b1, random_reg(), '0, random_reg()));
  endtask

  task automatic pool_exhaustion();
    rename_pkg::rename_req_t g0;
    rename_pkg::rename_req_t g1;
    rename_pkg::rename_rsp_t e0;
    rename_pkg::rename_rsp_t e1;
    rename_pkg::arch_idx_t   ra;
    rename_pkg::arch_idx_t   rb;
    logic                    got;
    while (count_free() > 0) begin
      g0 = make_req(1'b1, random_reg(), random_reg(), random_reg());
      g1 = make_req(count_free() > 1, random_reg(), random_reg(), random_reg());
      rename_group("pool_fill", g0, g1);
    end
    g0 = make_req(1'b1, random_reg(), random_reg(), random_reg());
    g1 = make_req(1'b1, random_reg(), random_reg(), random_reg());
    send_req(g0, g1);
    check_ack("pool_stall", 1'b0, 20, got);
    // Two renamed registers give back their committed tags
    ra = '0;
    rb = '0;
    for (int r = 1; r < rename_pkg::ARCH_REGS; r++) begin
      if (m_spec[r] != m_commit[r]) begin
        if (ra == '0) begin
          ra = rename_pkg::arch_idx_t'(r);
        end else if (rb == '0) begin
          rb = rename_pkg::arch_idx_t'(r);
        end
      end
    end
    pulse_commit(make_commit(ra, m_spec[ra]), make_commit(rb, m_spec[rb]));
    predict_rename(g0, g1, e0, e1);
    await_rsp("pool_release", e0, e1);
  endtask

  task automatic flush_restore();
    pulse_flush();
    rename_group("flush_spec",
                 make_req(1'b1, random_reg(), random_reg(), random_reg()),
                 make_req(1'b1, random_reg(), random_reg(), random_reg()));
    rename_group("flush_spec",
                 make_req(1'b1, random_reg(), random_reg(), random_reg()),
                 make_req(1'b1, random_reg(), random_reg(), random_reg()));
    pulse_flush();
    // Read back every architectural register
    for (int base = 0; base < rename_pkg::ARCH_REGS; base += 4) begin
      rename_group("flush_map",
                   make_req(1'b1, rename_pkg::arch_idx_t'(base),
                            rename_pkg::arch_idx_t'(base + 1), '0),
                   make_req(1'b1, rename_pkg::arch_idx_t'(base + 2),
                            rename_pkg::arch_idx_t'(base + 3), '0));
    end
    rename_group("flush_alloc",
                 make_req(1'b1, random_reg(), random_reg(), random_reg()),
                 make_req(1'b1, random_reg(), random_reg(), random_reg()));
  endtask

  initial begin
    repeat (16 + TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog expired after %0d cycles", 16 + TESTS * CYCLES_PER_TEST);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    errors = 0;
    req <= 1'b0;
    flush <= 1'b0;
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      req_group[l] <= '0;
      commit_group[l] <= '0;
    end
    init_model();
    void'($urandom(32'hb7e9_19f0));
    while (rst !== 1'b0) begin
      @(negedge clk);
    end
    reset_mapping();
    lane_forwarding();
    zero_register();
    pool_exhaustion();
    flush_restore();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/rename_pkg.sv
verilog/arch_map.sv
verilog/free_pool.sv
verilog/rename_ctrl.sv
verilog/rename_unit.sv
bench/clock_gen.sv
bench/tb_rename_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rename_unit \
  -f list.f --Mdir obj_dir -o tb_rename_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_rename_unit 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
